// ==== filelist.f ====
+incdir+verilog
verilog/dma_noc_pkg.sv
verilog/dma_ahb_pkg.sv
verilog/dma_packet_buffer.sv
verilog/dma_resp_ctrl.sv
verilog/dma_ahb_write_port.sv
verilog/dma_done_table.sv
verilog/dma_resp_top.sv
tb/dma_resp_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA response testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dma_resp_tb \
  -f filelist.f -o dma_resp_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/dma_resp_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// ==== tb/dma_resp_tb.sv ====
// Directed testbench for the DMA response top: memory model, stall source, compare tasks, timeout
`timescale 1ns/100ps
`default_nettype none

`include "dma_config.svh"

module dma_resp_tb;
  import dma_noc_pkg::*;
  import dma_ahb_pkg::*;

  // hready source modes
  localparam int HR_HIGH   = 0;
  localparam int HR_RANDOM = 1;
  localparam int HR_LOW    = 2;

  // Tests need a few hundred cycles at most
  localparam int CYCLE_LIMIT = 2000;

  logic                         clk;
  logic                         rst;
  logic [`DMA_FLIT_WIDTH-1:0]   noc_in_flit;
  logic                         noc_in_valid;
  logic                         noc_in_ready;
  logic                         hsel;
  logic [`DMA_ADDR_WIDTH-1:0]   haddr;
  logic [`DMA_ADDR_WIDTH-1:0]   hwdata;
  logic                         hwrite;
  ahb_trans_t                   htrans;
  ahb_burst_t                   hburst;
  logic                         hmastlock;
  logic                         hready;
  logic                         clr_en;
  table_pos_t                   clr_pos;
  logic [`DMA_TABLE_ENTRIES-1:0] done_flags;
  logic                         ctrl_done_en;
  table_pos_t                   ctrl_done_pos;

  int                           hready_mode;
  int                           cycle_count;

  // Accepted writes and completion events
  logic [`DMA_ADDR_WIDTH-1:0]   wr_addr_q[$];
  logic [`DMA_ADDR_WIDTH-1:0]   wr_data_q[$];
  ahb_trans_t                   wr_trans_q[$];
  ahb_burst_t                   wr_burst_q[$];
  logic                         wr_lock_q[$];
  table_pos_t                   done_q[$];

  // Flits to send and the data words they carry
  logic [`DMA_FLIT_WIDTH-1:0]   tx_q[$];
  logic [`DMA_ADDR_WIDTH-1:0]   exp_data_q[$];

  dma_resp_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .noc_in_flit   (noc_in_flit),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .hsel          (hsel),
    .haddr         (haddr),
    .hwdata        (hwdata),
    .hwrite        (hwrite),
    .htrans        (htrans),
    .hburst        (hburst),
    .hmastlock     (hmastlock),
    .hready        (hready),
    .clr_en        (clr_en),
    .clr_pos       (clr_pos),
    .done_flags    (done_flags),
    .ctrl_done_en  (ctrl_done_en),
    .ctrl_done_pos (ctrl_done_pos)
  );

  //////////////////////////////
  // Clock, stalls, monitors
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // hready changes on the falling edge and stalls one cycle in three in random mode
  initial begin
    hready = 1'b1;
    void'($urandom(10057));
    forever begin
      @(negedge clk);
      case (hready_mode)
        HR_RANDOM: hready = (($urandom % 3) != 0);
        HR_LOW:    hready = 1'b0;
        default:   hready = 1'b1;
      endcase
    end
  end

  // Memory model records a write when the slave takes it
  always @(posedge clk) begin
    if (!rst) begin
      if (hsel && hwrite && hready) begin
        wr_addr_q.push_back(haddr);
        wr_data_q.push_back(hwdata);
        wr_trans_q.push_back(htrans);
        wr_burst_q.push_back(hburst);
        wr_lock_q.push_back(hmastlock);
      end
      if (ctrl_done_en) begin
        done_q.push_back(ctrl_done_pos);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the DUT did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [`DMA_ADDR_WIDTH-1:0] exp, act);
    if (exp !== act) begin
      $display("Fail %s: data expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [`DMA_ADDR_WIDTH-1:0] exp, act);
    if (exp !== act) begin
      $display("Fail %s: address expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_trans(input string name, input ahb_trans_t exp, act);
    if (exp !== act) begin
      $display("Fail %s: htrans expected %s, actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_burst(input string name, input ahb_burst_t exp, act);
    if (exp !== act) begin
      $display("Fail %s: hburst expected %s, actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, act);
    if (exp !== act) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flags(input string name, input logic [`DMA_TABLE_ENTRIES-1:0] exp, act);
    if (exp !== act) begin
      $display("Fail %s: done flags expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pos(input string name, input table_pos_t exp, act);
    if (exp !== act) begin
      $display("Fail %s: done position expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, act);
    if (exp != act) begin
      $display("Fail %s: count expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  //////////////////////////////
  // Flit building and sending
  //////////////////////////////

  function automatic logic [`DMA_FLIT_WIDTH-1:0] header_flit(input flit_type_t ftype,
      input packet_type_t ptype, input logic last, input table_pos_t id);
    logic [`DMA_ADDR_WIDTH-1:0] content;
    content = '0;
    content[`DMA_PKT_TYPE_MSB:`DMA_PKT_TYPE_LSB] = ptype;
    content[`DMA_PKT_RESP_LAST] = last;
    content[`DMA_PKT_ID_MSB:`DMA_PKT_ID_LSB] = id;
    return {ftype, content};
  endfunction

  // R2L packet: header, size, start address, then data words
  task automatic queue_r2l(input table_pos_t id, input logic last,
      input logic [`DMA_ADDR_WIDTH-1:0] addr, input int n, input logic [15:0] tag);
    logic [`DMA_ADDR_WIDTH-1:0] word;
    tx_q.delete();
    exp_data_q.delete();
    tx_q.push_back(header_flit(FLIT_HEADER, PKT_R2L_RESP, last, id));
    tx_q.push_back({FLIT_PAYLOAD, `DMA_ADDR_WIDTH'(n)});
    tx_q.push_back({FLIT_PAYLOAD, addr});
    for (int i = 0; i < n; i++) begin
      word = {tag, 16'(i)};
      exp_data_q.push_back(word);
      tx_q.push_back({(i == n - 1) ? FLIT_LAST : FLIT_PAYLOAD, word});
    end
  endtask

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic send_flit(input logic [`DMA_FLIT_WIDTH-1:0] flit);
    noc_in_flit  = flit;
    noc_in_valid = 1'b1;
    while (!noc_in_ready) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic send_queued();
    foreach (tx_q[i]) send_flit(tx_q[i]);
    noc_in_valid = 1'b0;
  endtask

  task automatic clear_records();
    wr_addr_q.delete();
    wr_data_q.delete();
    wr_trans_q.delete();
    wr_burst_q.delete();
    wr_lock_q.delete();
    done_q.delete();
  endtask

  task automatic clear_flag(input table_pos_t pos);
    clr_en  = 1'b1;
    clr_pos = pos;
    @(negedge clk);
    clr_en  = 1'b0;
  endtask

  // Bus master released between bursts
  task automatic check_bus_idle(input string name);
    check_bit({name, " hsel"}, 1'b0, hsel);
    check_bit({name, " hwrite"}, 1'b0, hwrite);
    check_bit({name, " hmastlock"}, 1'b0, hmastlock);
    check_trans(name, HTRANS_IDLE, htrans);
  endtask

  // Word i goes to addr + 4i with NONSEQ first and SEQ after
  task automatic check_writes(input string name, input logic [`DMA_ADDR_WIDTH-1:0] addr,
      input int n);
    ahb_burst_t burst_exp;
    burst_exp = (n == 1) ? HBURST_SINGLE : HBURST_INCR;
    while (wr_data_q.size() < n) @(negedge clk);
    // Stray beats would show up in the next cycles
    repeat (2) @(negedge clk);
    check_count(name, n, wr_data_q.size());
    for (int i = 0; i < n; i++) begin
      check_addr(name, addr + `DMA_ADDR_WIDTH'(4 * i), wr_addr_q[i]);
      check_word(name, exp_data_q[i], wr_data_q[i]);
      check_trans(name, (i == 0) ? HTRANS_NONSEQ : HTRANS_SEQ, wr_trans_q[i]);
      check_burst(name, burst_exp, wr_burst_q[i]);
      check_bit({name, " hmastlock"}, 1'b1, wr_lock_q[i]);
    end
    check_bus_idle(name);
  endtask

  task automatic check_one_done(input string name, input table_pos_t pos);
    while (done_q.size() < 1) @(negedge clk);
    // A second pulse would follow within a cycle or two
    repeat (2) @(negedge clk);
    check_count(name, 1, done_q.size());
    check_pos(name, pos, done_q[0]);
  endtask

  // Holds hready low until the buffer pushes back
  task automatic release_on_full(input string name);
    while (noc_in_ready) @(negedge clk);
    check_count(name, 0, wr_data_q.size());
    hready_mode = HR_HIGH;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_state();
    check_bus_idle("reset_state");
    check_bit("reset_state ctrl_done_en", 1'b0, ctrl_done_en);
    check_bit("reset_state noc_in_ready", 1'b1, noc_in_ready);
    check_flags("reset_state", 4'b0000, done_flags);
  endtask

  task automatic test_l2r_ack();
    clear_records();
    tx_q.delete();
    tx_q.push_back(header_flit(FLIT_SINGLE, PKT_L2R_RESP, 1'b1, 2'd2));
    send_queued();
    check_one_done("l2r_ack", 2'd2);
    // One pulse only
    repeat (3) @(negedge clk);
    check_count("l2r_ack", 1, done_q.size());
    check_count("l2r_ack", 0, wr_data_q.size());
    check_flags("l2r_ack", 4'b0100, done_flags);
  endtask

  task automatic test_r2l_write();
    clear_records();
    queue_r2l(2'd1, 1'b1, 32'h0000_1000, 4, 16'hA100);
    send_queued();
    check_writes("r2l_write", 32'h0000_1000, 4);
    check_one_done("r2l_write", 2'd1);
    check_flags("r2l_write", 4'b0110, done_flags);
    // Without resp_last the flag stays clear
    clear_records();
    queue_r2l(2'd3, 1'b0, 32'h0000_2000, 1, 16'hA300);
    send_queued();
    check_writes("r2l_no_last", 32'h0000_2000, 1);
    repeat (3) @(negedge clk);
    check_count("r2l_no_last", 0, done_q.size());
    check_flags("r2l_no_last", 4'b0110, done_flags);
  endtask

  task automatic test_r2l_stall();
    clear_records();
    hready_mode = HR_RANDOM;
    queue_r2l(2'd0, 1'b1, 32'h0000_3000, 6, 16'hB000);
    send_queued();
    check_writes("r2l_stall", 32'h0000_3000, 6);
    hready_mode = HR_HIGH;
    check_one_done("r2l_stall", 2'd0);
    check_flags("r2l_stall", 4'b0111, done_flags);
  endtask

  task automatic test_clear();
    clear_flag(2'd1);
    check_flags("clear", 4'b0101, done_flags);
    clear_flag(2'd2);
    check_flags("clear", 4'b0001, done_flags);
  endtask

  task automatic test_discard();
    clear_records();
    // Request type on the response path is dropped whole
    tx_q.delete();
    tx_q.push_back(header_flit(FLIT_SINGLE, PKT_R2L_REQ, 1'b1, 2'd2));
    send_queued();
    queue_r2l(2'd1, 1'b1, 32'h0000_4000, 2, 16'hC100);
    send_queued();
    check_writes("discard", 32'h0000_4000, 2);
    check_one_done("discard", 2'd1);
    check_flags("discard", 4'b0011, done_flags);
  endtask

  task automatic test_backpressure();
    clear_records();
    hready_mode = HR_LOW;
    // 16 of the 20 data words fill the buffer while the bus stalls
    queue_r2l(2'd3, 1'b1, 32'h0000_5000, 20, 16'hD300);
    fork
      send_queued();
      release_on_full("backpressure");
    join
    check_writes("backpressure", 32'h0000_5000, 20);
    check_one_done("backpressure", 2'd3);
    check_flags("backpressure", 4'b1011, done_flags);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst          = 1'b1;
    noc_in_flit  = '0;
    noc_in_valid = 1'b0;
    clr_en       = 1'b0;
    clr_pos      = '0;
    hready_mode  = HR_HIGH;
    cycle_count  = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_l2r_ack();
    test_r2l_write();
    test_r2l_stall();
    test_clear();
    test_discard();
    test_backpressure();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/dma_ahb_pkg.sv ====
// AHB-Lite transfer and burst encodings
`default_nettype none

package dma_ahb_pkg;

  // HTRANS codes
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } ahb_trans_t;

  // HBURST codes, only SINGLE and INCR are issued here
  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001,
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } ahb_burst_t;

endpackage

`default_nettype wire

// ==== verilog/dma_ahb_write_port.sv ====
// Address counter and AHB-Lite write master signals
`timescale 1ns/100ps
`default_nettype none

`include "dma_config.svh"

module dma_ahb_write_port (
  input  wire                        clk,
  input  wire                        rst,
  input  wire [`DMA_ADDR_WIDTH-1:0]  flit_content,
  input  wire                        addr_load,
  input  wire                        burst_active,
  input  wire                        burst_single,
  input  wire                        hready,
  output logic                       beat_done,
  output logic                       hsel,
  output logic [`DMA_ADDR_WIDTH-1:0] haddr,
  output logic [`DMA_ADDR_WIDTH-1:0] hwdata,
  output logic                       hwrite,
  output dma_ahb_pkg::ahb_trans_t    htrans,
  output dma_ahb_pkg::ahb_burst_t    hburst,
  output logic                       hmastlock
);
  import dma_ahb_pkg::*;

  logic [`DMA_ADDR_WIDTH-1:0] addr;
  logic                       first_beat;

  // A beat completes when the slave is ready
  assign beat_done = burst_active & hready;

  //////////////////////////////
  // Address and first beat
  //////////////////////////////

  // Word steps, loaded from the address flit
  always_ff @(posedge clk) begin
    if (addr_load) begin
      addr <= flit_content;
    end else if (beat_done) begin
      addr <= addr + `DMA_ADDR_WIDTH'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      first_beat <= 1'b1;
    end else if (addr_load) begin
      first_beat <= 1'b1;
    end else if (beat_done) begin
      first_beat <= 1'b0;
    end
  end

  //////////////////////////////
  // Bus signals
  //////////////////////////////

  // Single phase, address and data in the same cycle
  assign haddr     = addr;
  assign hwdata    = flit_content;
  assign hsel      = burst_active;
  assign hwrite    = burst_active;
  assign hmastlock = burst_active;

  assign htrans = !burst_active ? HTRANS_IDLE :
                  first_beat    ? HTRANS_NONSEQ : HTRANS_SEQ;

  // Single only when the opening beat is already the last one
  assign hburst = (first_beat && burst_single) ? HBURST_SINGLE : HBURST_INCR;

endmodule

`default_nettype wire

// ==== verilog/dma_config.svh ====
// Sizes and flit field positions for the DMA response subsystem
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

//////////////////////////////
// Widths
//////////////////////////////

// Address and AHB data width
`define DMA_ADDR_WIDTH 32

// Flit is 2 type bits over 32 content bits
`define DMA_FLIT_WIDTH 34

//////////////////////////////
// Field positions
//////////////////////////////

// Flit type, top of every flit
`define DMA_FLIT_TYPE_MSB 33
`define DMA_FLIT_TYPE_LSB 32

// Header content fields
`define DMA_PKT_TYPE_MSB  31
`define DMA_PKT_TYPE_LSB  30
`define DMA_PKT_RESP_LAST 29
`define DMA_PKT_ID_MSB    28
`define DMA_PKT_ID_LSB    27

//////////////////////////////
// Sizes
//////////////////////////////

`define DMA_TABLE_ENTRIES 4
`define DMA_BUF_DEPTH     16

`endif

// ==== verilog/dma_done_table.sv ====
// Per-entry completion flags with set from the FSM and clear from software
`timescale 1ns/100ps
`default_nettype none

`include "dma_config.svh"

module dma_done_table (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          done_en,
  input  wire dma_noc_pkg::table_pos_t done_pos,
  input  wire                          clr_en,
  input  wire dma_noc_pkg::table_pos_t clr_pos,
  output logic [`DMA_TABLE_ENTRIES-1:0] done_flags
);

  always_ff @(posedge clk) begin
    if (rst) begin
      done_flags <= '0;
    end else begin
      if (clr_en) begin
        done_flags[clr_pos] <= 1'b0;
      end
      // Later assignment, so set wins on the same entry
      if (done_en) begin
        done_flags[done_pos] <= 1'b1;
      end
    end
  end

  // Software must clear an entry before it completes again
  a_no_double_done: assert property (@(posedge clk) disable iff (rst)
    done_en |-> !done_flags[done_pos]);

endmodule

`default_nettype wire

// ==== verilog/dma_noc_pkg.sv ====
// NoC flit type, packet type and table index types
`default_nettype none

`include "dma_config.svh"

package dma_noc_pkg;

  //////////////////////////////
  // Flit level
  //////////////////////////////

  // Flit type in bits 33:32 of every flit
  typedef enum logic [1:0] {
    FLIT_PAYLOAD = 2'b00,
    FLIT_HEADER  = 2'b01,
    FLIT_LAST    = 2'b10,
    // Header and last flit in one
    FLIT_SINGLE  = 2'b11
  } flit_type_t;

  //////////////////////////////
  // Packet level
  //////////////////////////////

  // Packet type in header bits 31:30
  typedef enum logic [1:0] {
    PKT_L2R_REQ  = 2'b00,
    PKT_R2L_REQ  = 2'b01,
    // Acknowledgment, no payload
    PKT_L2R_RESP = 2'b10,
    // Read data for local memory
    PKT_R2L_RESP = 2'b11
  } packet_type_t;

  // Request table entry index
  typedef logic [$clog2(`DMA_TABLE_ENTRIES)-1:0] table_pos_t;

endpackage

`default_nettype wire

// ==== verilog/dma_packet_buffer.sv ====
// Circular flit FIFO from the NoC input to the response control, with last-flit decode
`timescale 1ns/100ps
`default_nettype none

`include "dma_config.svh"

module dma_packet_buffer #(
  parameter int DEPTH = `DMA_BUF_DEPTH
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire [`DMA_FLIT_WIDTH-1:0]  in_flit,
  input  wire                        in_valid,
  output logic                       in_ready,
  output logic [`DMA_FLIT_WIDTH-1:0] out_flit,
  output logic                       out_valid,
  input  wire                        out_ready,
  output logic                       out_last
);
  import dma_noc_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Flit storage
  logic [`DMA_FLIT_WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  flit_type_t       head_type;

  // Wrap at DEPTH so any depth works
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  // Back-pressure only when every slot holds a flit
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  // Head entry and its type
  assign out_flit  = mem[rd_ptr];
  assign head_type = flit_type_t'(out_flit[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB]);
  assign out_last  = (head_type == FLIT_LAST) || (head_type == FLIT_SINGLE);

  //////////////////////////////
  // Storage and pointers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Occupancy follows push minus pop
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A push into a non-empty FIFO never lands on the unread head slot
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push && (count != '0) |-> (wr_ptr != rd_ptr));

endmodule

`default_nettype wire

// ==== verilog/dma_resp_ctrl.sv ====
// Response FSM that sorts L2R acknowledgments and R2L write-back packets
`timescale 1ns/100ps
`default_nettype none

`include "dma_config.svh"

module dma_resp_ctrl (
  input  wire                        clk,
  input  wire                        rst,
  input  wire [`DMA_FLIT_WIDTH-1:0]  buf_flit,
  input  wire                        buf_valid,
  input  wire                        buf_last,
  output logic                       buf_ready,
  input  wire                        beat_done,
  output logic                       addr_load,
  output logic                       burst_active,
  output logic                       burst_single,
  output logic                       done_en,
  output dma_noc_pkg::table_pos_t    done_pos
);
  import dma_noc_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_GET_SIZE,
    S_GET_ADDR,
    S_DATA
  } resp_state_t;

  resp_state_t  state;
  resp_state_t  state_nxt;

  // Header fields kept for the end of the burst
  table_pos_t   resp_id;
  logic         resp_last;
  logic         hdr_latch;

  // Header decode of the head flit
  packet_type_t hdr_type;
  table_pos_t   hdr_id;

  assign hdr_type = packet_type_t'(buf_flit[`DMA_PKT_TYPE_MSB:`DMA_PKT_TYPE_LSB]);
  assign hdr_id   = table_pos_t'(buf_flit[`DMA_PKT_ID_MSB:`DMA_PKT_ID_LSB]);

  //////////////////////////////
  // Next state and strobes
  //////////////////////////////

  always_comb begin
    state_nxt    = state;
    buf_ready    = 1'b0;
    addr_load    = 1'b0;
    burst_active = 1'b0;
    burst_single = 1'b0;
    done_en      = 1'b0;
    done_pos     = resp_id;
    hdr_latch    = 1'b0;

    case (state)
      S_IDLE: begin
        // Every header is popped, unknown types just vanish
        buf_ready = buf_valid;
        hdr_latch = buf_valid;
        if (buf_valid) begin
          if (hdr_type == PKT_L2R_RESP) begin
            // Acknowledgment completes at once
            done_en  = 1'b1;
            done_pos = hdr_id;
          end else if (hdr_type == PKT_R2L_RESP) begin
            state_nxt = S_GET_SIZE;
          end
        end
      end
      S_GET_SIZE: begin
        // Size flit is skipped, last flit marks the end
        buf_ready = buf_valid;
        if (buf_valid) begin
          state_nxt = S_GET_ADDR;
        end
      end
      S_GET_ADDR: begin
        buf_ready = buf_valid;
        addr_load = buf_valid;
        if (buf_valid) begin
          state_nxt = S_DATA;
        end
      end
      S_DATA: begin
        // Write port qualifies burst_single with its first-beat flag
        burst_active = buf_valid;
        burst_single = buf_valid & buf_last;
        // Data flit leaves only once the bus took it
        buf_ready    = beat_done;
        if (beat_done && buf_last) begin
          state_nxt = S_IDLE;
          done_en   = resp_last;
        end
      end
      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_latch) begin
      resp_id   <= hdr_id;
      resp_last <= buf_flit[`DMA_PKT_RESP_LAST];
    end
  end

  // Write port completes beats only for a data flit at the head
  a_beat_in_data: assert property (@(posedge clk) disable iff (rst)
    beat_done |-> (state == S_DATA) && buf_valid);

endmodule

`default_nettype wire

// ==== verilog/dma_resp_top.sv ====
// Top level of the DMA response path: buffer, FSM, AHB write port and done table
`timescale 1ns/100ps
`default_nettype none

`include "dma_config.svh"

module dma_resp_top (
  input  wire                           clk,
  input  wire                           rst,
  input  wire [`DMA_FLIT_WIDTH-1:0]     noc_in_flit,
  input  wire                           noc_in_valid,
  output logic                          noc_in_ready,
  output logic                          hsel,
  output logic [`DMA_ADDR_WIDTH-1:0]    haddr,
  output logic [`DMA_ADDR_WIDTH-1:0]    hwdata,
  output logic                          hwrite,
  output dma_ahb_pkg::ahb_trans_t       htrans,
  output dma_ahb_pkg::ahb_burst_t       hburst,
  output logic                          hmastlock,
  input  wire                           hready,
  input  wire                           clr_en,
  input  wire dma_noc_pkg::table_pos_t  clr_pos,
  output logic [`DMA_TABLE_ENTRIES-1:0] done_flags,
  output logic                          ctrl_done_en,
  output dma_noc_pkg::table_pos_t       ctrl_done_pos
);

  // Buffer head
  logic [`DMA_FLIT_WIDTH-1:0] buf_flit;
  logic                       buf_valid;
  logic                       buf_last;
  logic                       buf_ready;

  // FSM to write port
  logic                       addr_load;
  logic                       burst_active;
  logic                       burst_single;
  logic                       beat_done;

  dma_packet_buffer #(
    .DEPTH (`DMA_BUF_DEPTH)
  ) u_buffer (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in_flit),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (buf_flit),
    .out_valid (buf_valid),
    .out_ready (buf_ready),
    .out_last  (buf_last)
  );

  dma_resp_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .buf_flit     (buf_flit),
    .buf_valid    (buf_valid),
    .buf_last     (buf_last),
    .buf_ready    (buf_ready),
    .beat_done    (beat_done),
    .addr_load    (addr_load),
    .burst_active (burst_active),
    .burst_single (burst_single),
    .done_en      (ctrl_done_en),
    .done_pos     (ctrl_done_pos)
  );

  // Content bits of the head flit carry both address and data
  dma_ahb_write_port u_write_port (
    .clk          (clk),
    .rst          (rst),
    .flit_content (buf_flit[`DMA_ADDR_WIDTH-1:0]),
    .addr_load    (addr_load),
    .burst_active (burst_active),
    .burst_single (burst_single),
    .hready       (hready),
    .beat_done    (beat_done),
    .hsel         (hsel),
    .haddr        (haddr),
    .hwdata       (hwdata),
    .hwrite       (hwrite),
    .htrans       (htrans),
    .hburst       (hburst),
    .hmastlock    (hmastlock)
  );

  dma_done_table u_done_table (
    .clk        (clk),
    .rst        (rst),
    .done_en    (ctrl_done_en),
    .done_pos   (ctrl_done_pos),
    .clr_en     (clr_en),
    .clr_pos    (clr_pos),
    .done_flags (done_flags)
  );

endmodule

`default_nettype wire
